//--- Makefile
VERILATOR ?= verilator
TOP       ?= sifhTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- common/sifhCtrlPkg.sv
`default_nettype none

package sifhCtrlPkg;

    // coarse pass first, then the windowed fine pass
    typedef enum logic [3:0] {
        CLEAR1, BUILD1, DRAIN1, SCAN1, WINDOW,
        CLEAR2, BUILD2, DRAIN2, SCAN2, DONE
    } sifhPhase;

    typedef struct packed {
        sifhDataPkg::binIdx   coarse; // peak of the top bits
        sifhDataPkg::binIdx   fine;   // peak inside the coarse bin
        sifhDataPkg::binCount count;  // fine peak height
    } peakRes;

endpackage

`default_nettype wire

//--- common/sifhDataPkg.sv
`default_nettype none

package sifhDataPkg;

    // default sizes of the subsystem
    localparam int DEF_NP      = 12; // timestamp width
    localparam int DEF_NB      = 6;  // bin address width, 64 bins
    localparam int DEF_CB      = 4;  // count width, saturates at 15
    localparam int DEF_SAMPLES = 32; // accepted samples per pass

    // raw converter output
    typedef logic [DEF_NP-1:0] timeStamp;

    typedef logic [DEF_NB-1:0] binIdx;   // histogram address
    typedef logic [DEF_CB-1:0] binCount; // histogram word

    // one access to the histogram SRAM with both ports side by side
    typedef struct packed {
        logic    rdEn;   // read port enable
        binIdx   rdAddr;
        logic    wrEn;   // write port enable
        binIdx   wrAddr;
        binCount wrData;
    } ramReq;

endpackage

`default_nettype wire

//--- histogram/histBuilder.sv
`default_nettype none
`timescale 1ns/1ps

module histBuilder import sifhDataPkg::*; #(
    parameter int CB = DEF_CB
) (
    input  wire logic    clk,
    input  wire logic    res,
    input  wire logic    inc,
    input  wire binIdx   bin,
    input  wire binCount rdData,
    output ramReq        req,
    output logic         busy
);

    localparam binCount MAX_COUNT = binCount'({CB{1'b1}});

    logic    stage1Valid; // read issued
    logic    stage2Valid; // data back, write issued
    logic    lastValid;   // write committed last cycle
    binIdx   stage1Bin;
    binIdx   stage2Bin;
    binIdx   lastBin;
    binCount lastCount;
    binCount baseCount;
    binCount nextCount;
    logic    forward;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            stage1Valid <= 1'b0;
            stage2Valid <= 1'b0;
            lastValid   <= 1'b0;
        end else begin
            stage1Valid <= inc;
            stage2Valid <= stage1Valid;
            lastValid   <= stage2Valid;
        end
    end

    always_ff @(posedge clk) begin
        stage1Bin <= bin;
        stage2Bin <= stage1Bin;
        lastBin   <= stage2Bin;
        lastCount <= nextCount;
    end

    // the stage 2 read raced the previous write to the same bin
    assign forward   = lastValid && (lastBin == stage2Bin);
    assign baseCount = forward ? lastCount : rdData;
    assign nextCount = (baseCount == MAX_COUNT) ? MAX_COUNT : baseCount + 1'b1;

    always_comb begin
        req        = '0;
        req.rdEn   = stage1Valid;
        req.rdAddr = stage1Bin;
        req.wrEn   = stage2Valid;
        req.wrAddr = stage2Bin;
        req.wrData = nextCount;
    end

    assign busy = stage1Valid || stage2Valid;

endmodule

`default_nettype wire

//--- histogram/histRam.sv
`default_nettype none
`timescale 1ns/1ps

module histRam import sifhDataPkg::*; #(
    parameter int NB = DEF_NB,
    parameter int CB = DEF_CB
) (
    input  wire logic  clk,
    input  wire ramReq ramPort,
    output binCount    rdData
);

    logic [CB-1:0] mem [2**NB];

    always_ff @(posedge clk) begin
        if (ramPort.wrEn) begin
            mem[ramPort.wrAddr] <= ramPort.wrData;
        end
        if (ramPort.rdEn) begin
            rdData <= mem[ramPort.rdAddr]; // old word on a same-address write
        end
    end

    // a colliding read must belong to the builder, which rewrites that bin next cycle
    assert property (@(posedge clk)
        ramPort.rdEn && ramPort.wrEn && (ramPort.rdAddr == ramPort.wrAddr)
        |=> ramPort.wrEn && (ramPort.wrAddr == $past(ramPort.rdAddr)));

endmodule

`default_nettype wire

//--- histogram/peakFinder.sv
`default_nettype none
`timescale 1ns/1ps

module peakFinder import sifhDataPkg::*; #(
    parameter int NB = DEF_NB
) (
    input  wire logic    clk,
    input  wire logic    res,
    input  wire logic    start,
    input  wire binCount rdData,
    output ramReq        req,
    output logic         done,
    output binIdx        peakBin,
    output binCount      peakCount
);

    localparam binIdx LAST_BIN = binIdx'(2**NB - 1);

    logic  rdActive;
    logic  cmpValid; // rdData holds the word of cmpAddr
    binIdx rdAddr;
    binIdx cmpAddr;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rdActive <= 1'b0;
            cmpValid <= 1'b0;
            rdAddr   <= '0;
            done     <= 1'b0;
        end else begin
            cmpValid <= rdActive;
            done     <= cmpValid && (cmpAddr == LAST_BIN); // start + 2^NB + 2
            if (start) begin
                rdActive <= 1'b1;
                rdAddr   <= '0;
            end else if (rdActive) begin
                if (rdAddr == LAST_BIN) begin
                    rdActive <= 1'b0;
                end
                rdAddr <= rdAddr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        cmpAddr <= rdAddr;
        if (start) begin
            peakBin   <= '0;
            peakCount <= '0;
        end else if (cmpValid && (rdData > peakCount)) begin
            peakBin   <= cmpAddr; // lowest bin keeps a tie
            peakCount <= rdData;
        end
    end

    always_comb begin
        req        = '0;
        req.rdEn   = rdActive;
        req.rdAddr = rdAddr;
    end

    // control waits for done before it can start the next scan
    assert property (@(posedge clk) disable iff (!res)
        start |-> !(rdActive || cmpValid));

endmodule

`default_nettype wire

//--- source/binMapper.sv
`default_nettype none
`timescale 1ns/1ps

module binMapper import sifhDataPkg::*; #(
    parameter int NP = DEF_NP,
    parameter int NB = DEF_NB
) (
    input  wire timeStamp sample,
    input  wire logic     fine,   // second pass
    input  wire binIdx    window, // coarse peak bin
    output binIdx         bin,
    output logic          hit
);

    binIdx coarseBits;
    binIdx fineBits;

    assign coarseBits = sample[NP-1 -: NB];      // top bits
    assign fineBits   = sample[NP-NB-1 -: NB];   // next bits below them

    always_comb begin
        if (fine) begin
            bin = fineBits;
            hit = coarseBits == window; // outside the window is dropped
        end else begin
            bin = coarseBits;
            hit = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/sifhControl.sv
`default_nettype none
`timescale 1ns/1ps

module sifhControl import sifhDataPkg::*; import sifhCtrlPkg::*; #(
    parameter int NB      = DEF_NB,
    parameter int SAMPLES = DEF_SAMPLES
) (
    input  wire logic    clk,
    input  wire logic    res,
    input  wire logic    sampleValid,
    input  wire logic    hit,
    output logic         fine,
    output binIdx        window,
    output logic         ready,
    output logic         inc,
    input  wire logic    builderBusy,
    input  wire ramReq   builderReq,
    output logic         scanStart,
    input  wire logic    scanDone,
    input  wire binIdx   peakBin,
    input  wire binCount peakCount,
    input  wire ramReq   scanReq,
    output ramReq        ramPort,
    output peakRes       result,
    output logic         resultValid
);

    localparam int SW = $clog2(SAMPLES + 1);
    localparam binIdx LAST_BIN = binIdx'(2**NB - 1);
    localparam logic [SW-1:0] LAST_SAMPLE = SW'(SAMPLES - 1);

    sifhPhase phase, nextPhase;
    binIdx clearAddr;
    ramReq clearReq;
    logic [SW-1:0] sampleCnt;
    logic accept;
    logic lastClear;
    logic lastSample;
    logic clearing, building, draining, scanning;

    assign clearing = phase inside {CLEAR1, CLEAR2};
    assign building = phase inside {BUILD1, BUILD2};
    assign draining = phase inside {DRAIN1, DRAIN2};
    assign scanning = phase inside {SCAN1, SCAN2};
    assign fine     = phase inside {CLEAR2, BUILD2, DRAIN2, SCAN2};

    assign ready      = building; // BUILD ends on the last accepted sample
    assign accept     = sampleValid && ready;
    assign inc        = accept && hit; // rejected fine samples still count below
    assign lastClear  = clearAddr == LAST_BIN;
    assign lastSample = accept && (sampleCnt == LAST_SAMPLE);
    assign scanStart  = draining && !builderBusy;

    always_comb begin
        nextPhase = phase;
        case (phase)
            CLEAR1: if (lastClear) nextPhase = BUILD1;
            BUILD1: if (lastSample) nextPhase = DRAIN1;
            DRAIN1: if (!builderBusy) nextPhase = SCAN1;
            SCAN1:  if (scanDone) nextPhase = WINDOW;
            WINDOW: nextPhase = CLEAR2;
            CLEAR2: if (lastClear) nextPhase = BUILD2;
            BUILD2: if (lastSample) nextPhase = DRAIN2;
            DRAIN2: if (!builderBusy) nextPhase = SCAN2;
            SCAN2:  if (scanDone) nextPhase = DONE;
            DONE:   nextPhase = CLEAR1; // next measurement
            default: nextPhase = CLEAR1;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase       <= CLEAR1;
            clearAddr   <= '0;
            clearReq    <= '0;
            sampleCnt   <= '0;
            resultValid <= 1'b0;
        end else begin
            phase          <= nextPhase;
            resultValid    <= phase == DONE;
            clearReq.wrEn  <= clearing; // zero writes trail the counter by one cycle
            clearReq.wrAddr <= clearAddr;
            if (clearing) begin
                clearAddr <= clearAddr + 1'b1; // wraps to 0 at the end
            end
            if (accept) begin
                sampleCnt <= lastSample ? '0 : sampleCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (phase == WINDOW) begin
            window <= peakBin; // coarse peak gates the fine pass
        end
        if (phase == DONE) begin
            result.coarse <= window;
            result.fine   <= peakBin;
            result.count  <= peakCount;
        end
    end

    // the trailing clear write lands in the first build cycle before any read
    always_comb begin
        ramPort = '0;
        if (building || draining) begin
            ramPort = builderReq;
        end else if (scanning) begin
            ramPort = scanReq;
        end
        if (clearReq.wrEn) begin
            ramPort = clearReq;
        end
    end

    // histogram must be settled before and during the scan
    assert property (@(posedge clk) disable iff (!res)
        scanning |-> !builderBusy && !builderReq.wrEn && !clearReq.wrEn);

endmodule

`default_nettype wire

//--- source/sifhTop.sv
`default_nettype none
`timescale 1ns/1ps

module sifhTop import sifhDataPkg::*; import sifhCtrlPkg::*; #(
    parameter int NP      = DEF_NP,
    parameter int NB      = DEF_NB,
    parameter int CB      = DEF_CB,
    parameter int SAMPLES = DEF_SAMPLES
) (
    input  wire logic     clk,
    input  wire logic     res,
    input  wire timeStamp sample,
    input  wire logic     sampleValid,
    output logic          ready,
    output peakRes        result,
    output logic          resultValid
);

    logic    fine;
    binIdx   window;
    binIdx   bin;
    logic    hit;
    logic    inc;
    logic    builderBusy;
    ramReq   builderReq;
    logic    scanStart;
    logic    scanDone;
    binIdx   peakBin;
    binCount peakCount;
    ramReq   scanReq;
    ramReq   ramPort;
    binCount rdData;

    sifhControl #(.NB(NB), .SAMPLES(SAMPLES)) control (
        .clk(clk), .res(res),
        .sampleValid(sampleValid), .hit(hit),
        .fine(fine), .window(window), .ready(ready), .inc(inc),
        .builderBusy(builderBusy), .builderReq(builderReq),
        .scanStart(scanStart), .scanDone(scanDone),
        .peakBin(peakBin), .peakCount(peakCount), .scanReq(scanReq),
        .ramPort(ramPort), .result(result), .resultValid(resultValid)
    );

    binMapper #(.NP(NP), .NB(NB)) mapper (
        .sample(sample), .fine(fine), .window(window),
        .bin(bin), .hit(hit)
    );

    histRam #(.NB(NB), .CB(CB)) ram (
        .clk(clk), .ramPort(ramPort), .rdData(rdData)
    );

    histBuilder #(.CB(CB)) builder (
        .clk(clk), .res(res), .inc(inc), .bin(bin),
        .rdData(rdData), .req(builderReq), .busy(builderBusy)
    );

    peakFinder #(.NB(NB)) finder (
        .clk(clk), .res(res), .start(scanStart), .rdData(rdData),
        .req(scanReq), .done(scanDone),
        .peakBin(peakBin), .peakCount(peakCount)
    );

endmodule

`default_nettype wire

//--- sources.f
common/sifhDataPkg.sv
common/sifhCtrlPkg.sv
source/binMapper.sv
histogram/histRam.sv
histogram/histBuilder.sv
histogram/peakFinder.sv
source/sifhControl.sv
source/sifhTop.sv
test/sifhTb.sv

//--- test/sifhTb.sv
`default_nettype none
`timescale 1ns/1ps

module sifhTb
    import sifhDataPkg::*;
    import sifhCtrlPkg::*;
();

    localparam int NP      = DEF_NP;
    localparam int NB      = DEF_NB;
    localparam int CB      = DEF_CB;
    localparam int SAMPLES = DEF_SAMPLES;

    logic     clk;
    logic     res;
    timeStamp sample;
    logic     sampleValid;
    logic     ready;
    peakRes   result;
    logic     resultValid;

    timeStamp    sampleList [$]; // SAMPLES entries per test
    int          gapList [$];    // longest idle gap between samples
    peakRes      expectList [$];
    int unsigned cycleCount = 0;
    int unsigned cycleLimit;

    sifhTop #(.NP(NP), .NB(NB), .CB(CB), .SAMPLES(SAMPLES)) uut (
        .clk(clk), .res(res), .sample(sample), .sampleValid(sampleValid),
        .ready(ready), .result(result), .resultValid(resultValid)
    );

    always #10 clk = ~clk;

    task automatic reportMismatch(input string what);
        $display("[FAIL] t=%0t %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "result mismatch");
    endtask

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    always @(posedge clk) begin
        if (res) begin
            cycleCount++;
            if (cycleCount >= cycleLimit) begin
                abortRun($sformatf("timeout, no result within %0d cycles", cycleLimit));
            end
        end
    end

    task automatic loadTests();
        int          fd;
        int          n;
        int          i;
        int          gapVal;
        string       line;
        byte         tag;
        logic [31:0] vals [8];
        logic [31:0] eCoarse;
        logic [31:0] eFine;
        logic [31:0] eCount;
        peakRes      want;
        fd = $fopen("test/sifhTests.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open test/sifhTests.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0) begin
                continue;
            end
            tag = line[0];
            if (tag == "T") begin
                n = $sscanf(line, "T %d", gapVal);
                gapList.push_back(gapVal);
            end else if (tag == "S") begin
                n = $sscanf(line, "S %h %h %h %h %h %h %h %h", vals[0], vals[1],
                            vals[2], vals[3], vals[4], vals[5], vals[6], vals[7]);
                for (i = 0; i < n; i++) begin
                    sampleList.push_back(timeStamp'(vals[i]));
                end
            end else if (tag == "E") begin
                n = $sscanf(line, "E %h %h %h", eCoarse, eFine, eCount);
                want.coarse = binIdx'(eCoarse);
                want.fine   = binIdx'(eFine);
                want.count  = binCount'(eCount);
                expectList.push_back(want);
                if (gapList.size() != expectList.size() ||
                    sampleList.size() != expectList.size() * SAMPLES) begin
                    abortRun($sformatf("test file malformed in test %0d", expectList.size()));
                end
            end
        end
        $fclose(fd);
        if (expectList.size() == 0) begin
            abortRun("test file holds no tests");
        end
    endtask

    // drives one pass over the samples of a test 1 ns after each rising edge
    task automatic runPass(input int base, input int maxGap, output int lowCycles);
        int   idx;
        int   gap;
        logic drvValid;
        logic drvReady;
        idx       = 0;
        gap       = 0;
        lowCycles = 0;
        while (idx < SAMPLES) begin
            sample   = sampleList[base + idx];
            drvReady = ready; // only changes on a clock edge
            if (!ready) begin
                sampleValid = 1'b1; // held while not ready and dropped by the DUT
                lowCycles++;
            end else if (gap > 0) begin
                sampleValid = 1'b0;
                gap--;
            end else begin
                sampleValid = 1'b1;
            end
            drvValid = sampleValid;
            @(posedge clk);
            #1;
            if (drvValid && drvReady) begin
                idx++;
                gap = int'($urandom_range(maxGap, 0));
            end
        end
        sampleValid = 1'b0;
    endtask

    task automatic checkResult(input int t);
        peakRes want;
        want = expectList[t];
        while (!resultValid) begin
            @(negedge clk);
        end
        assert (result.coarse == want.coarse)
            else reportMismatch($sformatf("test %0d coarse bin %h, expected %h",
                                          t, result.coarse, want.coarse));
        assert (result.fine == want.fine)
            else reportMismatch($sformatf("test %0d fine bin %h, expected %h",
                                          t, result.fine, want.fine));
        assert (result.count == want.count)
            else reportMismatch($sformatf("test %0d count %h, expected %h",
                                          t, result.count, want.count));
        @(posedge clk);
        #1;
        assert (!resultValid)
            else reportMismatch($sformatf("test %0d resultValid longer than one cycle", t));
    endtask

    initial begin
        int t;
        int lowCycles;
        clk         = 1'b0;
        res         = 1'b0;
        sample      = '0;
        sampleValid = 1'b0;
        void'($urandom(99));
        loadTests();
        cycleLimit = expectList.size() * (2 * SAMPLES * 4 + 4 * (2**NB) + 50);
        repeat (10) @(posedge clk);
        #1;
        assert (!ready && !resultValid)
            else reportMismatch("ready or resultValid high during reset");
        res = 1'b1;
        for (t = 0; t < expectList.size(); t++) begin
            runPass(t * SAMPLES, gapList[t], lowCycles);
            if (t == 0) begin
                // first clear covers every bin before the first sample
                assert (lowCycles == 2**NB)
                    else reportMismatch($sformatf("ready low for %0d cycles after reset",
                                                  lowCycles));
            end
            runPass(t * SAMPLES, gapList[t], lowCycles); // fine pass with the same samples
            checkResult(t);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/sifhTests.txt
# T max gap in cycles | S eight 12-bit hex samples | E coarse bin, fine bin, count (hex)
# every test has 32 samples, replayed in both passes
T 3
S 523 A05 523 524 C3F 523 510 123
S 523 F01 524 523 A05 510 523 C3F
S A05 523 524 123 F01 523 C3F A05
S 510 523 524 F01 123 C3F A05 523
E 14 23 A
T 3
S 805 230 806 211 805 F3F 230 400
S 806 211 805 230 202 806 F3F 211
S 400 805 230 806 211 F3F 805 202
S 806 400 230 211 805 806 F3F 400
E 08 11 5
T 3
S 72A 72A 300 72A 72A 72B 72A 72A
S 300 72A 72A 72A 300 72A 72B 72A
S 72A 300 72A 72A 72B 72A 300 72A
S 72A 72A 300 72B 72A 300 72A 300
E 1C 2A F
T 3
S 915 115 D15 902 915 E02 115 915
S D15 915 E02 902 115 915 D15 E02
S 915 E02 115 D15 915 902 E02 115
S D15 915 E02 115 902 D15 915 E02
E 24 15 9
T 0
S B07 B07 B07 B07 B07 B07 B07 B07
S B07 B07 B07 B08 B08 B08 B07 B08
S B07 B08 C20 C20 C20 C20 C20 C20
S 400 400 400 B3F 400 400 400 B3F
E 2C 07 D
T 3
S 031 635 A10 636 635 A10 635 A10
S 635 635 A10 636 635 A10 635 635
S A10 636 635 A10 635 A10 636 635
S 635 A10 635 636 A10 635 A10 A10
E 18 35 E
